/* include/ex16_macros.svh */
// Widths are fixed by the 16-bit encoding; changing them breaks the instruction formats
`ifndef EX16_MACROS_SVH
`define EX16_MACROS_SVH

////////////////////////////////////////////////////////////
// Datapath widths
////////////////////////////////////////////////////////////

`define EX16_DATA_W 16 // Data word and instruction word

// Register file
`define EX16_NREGS 16 // Register 0 reads as zero
`define EX16_REG_W 4  // Register index

// Instruction fields
`define EX16_OPC_W 4 // Top nibble of the word

`endif

/* design/ex16_pkg.sv */
// Opcodes outside the enumeration are illegal; flag positions match the 3-bit flag register
`default_nettype none

`include "ex16_macros.svh"

package ex16_pkg;

    ////////////////////////////////////////////////////////////
    // Opcodes
    ////////////////////////////////////////////////////////////

    typedef enum logic [`EX16_OPC_W-1:0] {
        OPC_ADD = 4'd0,  // Saturating add
        OPC_SUB = 4'd1,  // Saturating subtract
        OPC_AND = 4'd2,
        OPC_NOR = 4'd3,
        OPC_SLL = 4'd4,  // Shift by immediate nibble
        OPC_SRL = 4'd5,
        OPC_SRA = 4'd6,
        OPC_LHB = 4'd10, // Load high byte
        OPC_LLB = 4'd11  // Load low byte
    } ex16_opc_e;

    // Bit positions inside the flag register
    typedef enum int unsigned {
        FLAG_N = 0, // Sign of result
        FLAG_V = 1, // Signed overflow
        FLAG_Z = 2  // Zero result
    } ex16_flag_e;

    ////////////////////////////////////////////////////////////
    // Instruction formats
    ////////////////////////////////////////////////////////////

    // Register ops
    typedef struct packed {
        ex16_opc_e             opcode;
        logic [`EX16_REG_W-1:0] rd;
        logic [`EX16_REG_W-1:0] rs;
        logic [`EX16_REG_W-1:0] rt;
    } ex16_rfmt_s;

    // Shifts reuse the rt slot as amount
    typedef struct packed {
        ex16_opc_e             opcode;
        logic [`EX16_REG_W-1:0] rd;
        logic [`EX16_REG_W-1:0] rs;
        logic [3:0]            shamt;
    } ex16_sfmt_s;

    // Load half ops where rd is also the source
    typedef struct packed {
        ex16_opc_e             opcode;
        logic [`EX16_REG_W-1:0] rd;
        logic [7:0]            imm8;
    } ex16_ifmt_s;

    // One word, three views
    typedef union packed {
        ex16_rfmt_s r;
        ex16_sfmt_s s;
        ex16_ifmt_s i;
    } ex16_instr_u;

endpackage

`default_nettype wire

/* design/ex16_alu.sv */
// Combinational only; LHB, LLB and illegal codes give zero with an empty flag mask
`default_nettype none

`include "ex16_macros.svh"

module ex16_alu import ex16_pkg::*; (
    input  logic [`EX16_DATA_W-1:0] a,
    input  logic [`EX16_DATA_W-1:0] b,
    input  logic [3:0]              shamt,
    input  ex16_opc_e               op,
    output logic [`EX16_DATA_W-1:0] result,
    output logic [2:0]              flags,
    output logic [2:0]              flag_mask
);

    logic [`EX16_DATA_W-1:0] sum;
    logic [`EX16_DATA_W-1:0] diff;
    logic [`EX16_DATA_W-1:0] sat_val; // Clamp value picked from sign of a
    logic                    add_ovf;
    logic                    sub_ovf;
    logic                    ovf;

    ////////////////////////////////////////////////////////////
    // Saturating add and subtract
    ////////////////////////////////////////////////////////////

    assign sum  = a + b;
    assign diff = a - b;

    // Same signs in, other sign out
    assign add_ovf = (a[`EX16_DATA_W-1] == b[`EX16_DATA_W-1]) &&
                     (sum[`EX16_DATA_W-1] != a[`EX16_DATA_W-1]);
    // Opposite signs in, sign of a lost
    assign sub_ovf = (a[`EX16_DATA_W-1] != b[`EX16_DATA_W-1]) &&
                     (diff[`EX16_DATA_W-1] != a[`EX16_DATA_W-1]);

    // Negative a overflows downward
    assign sat_val = a[`EX16_DATA_W-1] ? {1'b1, {(`EX16_DATA_W-1){1'b0}}}
                                       : {1'b0, {(`EX16_DATA_W-1){1'b1}}};

    always_comb begin
        result    = '0;
        ovf       = 1'b0;
        flag_mask = '0;
        case (op)
            OPC_ADD: begin
                result    = add_ovf ? sat_val : sum;
                ovf       = add_ovf;
                flag_mask = 3'b111; // Z, V and N
            end
            OPC_SUB: begin
                result    = sub_ovf ? sat_val : diff;
                ovf       = sub_ovf;
                flag_mask = 3'b111;
            end
            OPC_AND: result = a & b;
            OPC_NOR: result = ~(a | b);
            OPC_SLL: result = a << shamt;
            OPC_SRL: result = a >> shamt;
            OPC_SRA: result = $signed(a) >>> shamt; // Sign fill
            default: result = '0;
        endcase
        // Logic and shift ops touch Z only
        if (op inside {OPC_AND, OPC_NOR, OPC_SLL, OPC_SRL, OPC_SRA})
            flag_mask[FLAG_Z] = 1'b1;
    end

    ////////////////////////////////////////////////////////////
    // Flags from the saturated result
    ////////////////////////////////////////////////////////////

    always_comb begin
        flags         = '0;
        flags[FLAG_Z] = (result == '0);
        flags[FLAG_V] = ovf;
        flags[FLAG_N] = result[`EX16_DATA_W-1];
    end

endmodule

`default_nettype wire

/* design/ex16_decode.sv */
// Without forwarding, a source matching a pending write in decode or execute holds in_ready low
`default_nettype none

`include "ex16_macros.svh"

module ex16_decode import ex16_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    // Instruction input
    input  logic                    in_valid,
    output logic                    in_ready,
    input  ex16_instr_u             in_instr,
    // Register file read
    output logic [`EX16_REG_W-1:0]  rf_a_idx,
    output logic [`EX16_REG_W-1:0]  rf_b_idx,
    input  logic [`EX16_DATA_W-1:0] rf_a,
    input  logic [`EX16_DATA_W-1:0] rf_b,
    // Execute register occupancy
    input  logic                    ex_valid,
    input  logic [`EX16_REG_W-1:0]  ex_rd,
    // To execute
    output logic                    dec_valid,
    input  logic                    dec_ready,
    output ex16_opc_e               dec_op,
    output logic [`EX16_REG_W-1:0]  dec_rd,
    output logic [`EX16_DATA_W-1:0] dec_a,
    output logic [`EX16_DATA_W-1:0] dec_b,
    output logic [7:0]              dec_imm8,
    output logic [3:0]              dec_shamt,
    output logic                    dec_illegal
);

    logic                   use_a;      // rs is read
    logic                   use_b;      // rt or rd is read
    logic                   is_lh;      // LHB or LLB
    logic                   illegal;
    logic [`EX16_REG_W-1:0] src_a;
    logic [`EX16_REG_W-1:0] src_b;
    logic                   haz_a;
    logic                   haz_b;
    logic                   accept;
    logic                   ex_wr_seen; // Mirrors ex_wr of the execute item

    ////////////////////////////////////////////////////////////
    // Field split and source select
    ////////////////////////////////////////////////////////////

    always_comb begin
        use_a   = 1'b0;
        use_b   = 1'b0;
        is_lh   = 1'b0;
        illegal = 1'b0;
        case (in_instr.r.opcode)
            OPC_ADD, OPC_SUB, OPC_AND, OPC_NOR: begin
                use_a = 1'b1;
                use_b = 1'b1;
            end
            OPC_SLL, OPC_SRL, OPC_SRA: use_a = 1'b1; // rt slot holds shamt
            OPC_LHB, OPC_LLB: begin
                use_b = 1'b1; // Old rd keeps the other byte
                is_lh = 1'b1;
            end
            default: illegal = 1'b1; // Reads nothing, never stalls
        endcase
    end

    assign src_a    = in_instr.r.rs;
    assign src_b    = is_lh ? in_instr.i.rd : in_instr.r.rt;
    assign rf_a_idx = src_a;
    assign rf_b_idx = src_b;

    ////////////////////////////////////////////////////////////
    // Hazard check against both stage registers
    ////////////////////////////////////////////////////////////

    // Register 0 never matches
    assign haz_a = use_a && (src_a != '0) &&
                   ((dec_valid && !dec_illegal && (dec_rd == src_a)) ||
                    (ex_valid && ex_wr_seen && (ex_rd == src_a)));
    assign haz_b = use_b && (src_b != '0) &&
                   ((dec_valid && !dec_illegal && (dec_rd == src_b)) ||
                    (ex_valid && ex_wr_seen && (ex_rd == src_b)));

    // Take a word when the slot frees and no source is in flight
    assign in_ready = (!dec_valid || dec_ready) && !(in_valid && (haz_a || haz_b));
    assign accept   = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            dec_valid  <= 1'b0;
            ex_wr_seen <= 1'b0;
        end else begin
            if (accept)
                dec_valid <= 1'b1;
            else if (dec_ready)
                dec_valid <= 1'b0; // Item left, slot empty
            if (dec_valid && dec_ready)
                ex_wr_seen <= !dec_illegal; // Loads with the execute register
        end
    end

    // Payload
    always_ff @(posedge clk) begin
        if (accept) begin
            dec_op      <= in_instr.r.opcode;
            dec_rd      <= in_instr.r.rd;
            dec_a       <= rf_a;
            dec_b       <= rf_b;
            dec_imm8    <= in_instr.i.imm8;
            dec_shamt   <= in_instr.s.shamt;
            dec_illegal <= illegal;
        end
    end

endmodule

`default_nettype wire

/* design/ex16_execute.sv */
// One-entry stage; ex_wr stays low for illegal ops and rd 0 so decode and result can trust it
`default_nettype none

`include "ex16_macros.svh"

module ex16_execute import ex16_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    // From decode
    input  logic                    dec_valid,
    output logic                    dec_ready,
    input  ex16_opc_e               dec_op,
    input  logic [`EX16_REG_W-1:0]  dec_rd,
    input  logic [`EX16_DATA_W-1:0] dec_a,
    input  logic [`EX16_DATA_W-1:0] dec_b,
    input  logic [7:0]              dec_imm8,
    input  logic [3:0]              dec_shamt,
    input  logic                    dec_illegal,
    // To result
    output logic                    ex_valid,
    input  logic                    ex_ready,
    output logic [`EX16_REG_W-1:0]  ex_rd,
    output logic [`EX16_DATA_W-1:0] ex_data,
    output logic [2:0]              ex_flags,
    output logic [2:0]              ex_flag_mask,
    output logic                    ex_wr,
    output logic                    ex_illegal
);

    logic [`EX16_DATA_W-1:0] alu_result;
    logic [2:0]              alu_flags;
    logic [2:0]              alu_mask;
    logic [`EX16_DATA_W-1:0] lh_result; // Load-half merge
    logic [`EX16_DATA_W-1:0] op2_result;
    logic                    load;

    ex16_alu alu0 (
        .a         (dec_a),
        .b         (dec_b),
        .shamt     (dec_shamt),
        .op        (dec_op),
        .result    (alu_result),
        .flags     (alu_flags),
        .flag_mask (alu_mask)
    );

    ////////////////////////////////////////////////////////////
    // LHB / LLB merge and result select
    ////////////////////////////////////////////////////////////

    // dec_b carries the old rd value here
    assign lh_result = (dec_op == OPC_LHB) ? {dec_imm8, dec_b[7:0]}
                                           : {dec_b[15:8], dec_imm8};

    always_comb begin
        if ((dec_op == OPC_LHB) || (dec_op == OPC_LLB))
            op2_result = lh_result;  // Bypasses the ALU
        else
            op2_result = alu_result;
    end

    assign dec_ready = !ex_valid || ex_ready; // Empty or draining this edge
    assign load      = dec_valid && dec_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_valid <= 1'b0;
            ex_wr    <= 1'b0;
        end else if (load) begin
            ex_valid <= 1'b1;
            ex_wr    <= !dec_illegal && (dec_rd != '0); // Register 0 dropped here
        end else if (ex_ready) begin
            ex_valid <= 1'b0;
            ex_wr    <= 1'b0;
        end
    end

    // Payload
    always_ff @(posedge clk) begin
        if (load) begin
            ex_rd        <= dec_rd;
            ex_data      <= op2_result;
            ex_flags     <= alu_flags;
            ex_flag_mask <= alu_mask; // Zero for illegal codes
            ex_illegal   <= dec_illegal;
        end
    end

endmodule

`default_nettype wire

/* design/ex16_result.sv */
// Register file and flags update on the edge the output register loads; reads are combinational
`default_nettype none

`include "ex16_macros.svh"

module ex16_result (
    input  logic                    clk,
    input  logic                    rst,
    // Decode read ports
    input  logic [`EX16_REG_W-1:0]  rf_a_idx,
    input  logic [`EX16_REG_W-1:0]  rf_b_idx,
    output logic [`EX16_DATA_W-1:0] rf_a,
    output logic [`EX16_DATA_W-1:0] rf_b,
    // From execute
    input  logic                    ex_valid,
    output logic                    ex_ready,
    input  logic [`EX16_REG_W-1:0]  ex_rd,
    input  logic [`EX16_DATA_W-1:0] ex_data,
    input  logic [2:0]              ex_flags,
    input  logic [2:0]              ex_flag_mask,
    input  logic                    ex_wr,
    input  logic                    ex_illegal,
    // Retired results
    output logic                    res_valid,
    input  logic                    res_ready,
    output logic [`EX16_DATA_W-1:0] res_data,
    output logic [`EX16_REG_W-1:0]  res_rd,
    output logic [2:0]              res_flags,
    output logic                    res_illegal
);

    logic [`EX16_DATA_W-1:0] regs [`EX16_NREGS];
    logic [2:0]              flag_q;    // Z V N
    logic [2:0]              flag_next;
    logic                    load;

    ////////////////////////////////////////////////////////////
    // Register file
    ////////////////////////////////////////////////////////////

    // Entry 0 is never written so it reads zero
    assign rf_a = regs[rf_a_idx];
    assign rf_b = regs[rf_b_idx];

    assign ex_ready  = !res_valid || res_ready;
    assign load      = ex_valid && ex_ready;
    // Only masked bits change
    assign flag_next = (flag_q & ~ex_flag_mask) | (ex_flags & ex_flag_mask);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `EX16_NREGS; i++)
                regs[i] <= '0;
            flag_q    <= '0;
            res_valid <= 1'b0;
        end else if (load) begin
            if (ex_wr)
                regs[ex_rd] <= ex_data; // Low for illegal and rd 0
            flag_q    <= flag_next;
            res_valid <= 1'b1;
        end else if (res_ready) begin
            res_valid <= 1'b0; // Consumed, nothing behind it
        end
    end

    ////////////////////////////////////////////////////////////
    // Output register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (load) begin
            res_data    <= ex_data;
            res_rd      <= ex_rd;
            res_illegal <= ex_illegal;
        end
    end

    // Flag register only moves on a load, so it is this item's value
    assign res_flags = flag_q;

endmodule

`default_nettype wire

/* design/ex16_top.sv */
// Three stages, no forwarding; a dependent instruction waits in front of decode
`default_nettype none

`include "ex16_macros.svh"

module ex16_top import ex16_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    in_valid,
    output logic                    in_ready,
    input  logic [`EX16_DATA_W-1:0] in_instr,
    output logic                    res_valid,
    input  logic                    res_ready,
    output logic [`EX16_DATA_W-1:0] res_data,
    output logic [`EX16_REG_W-1:0]  res_rd,
    output logic [2:0]              res_flags,
    output logic                    res_illegal
);

    // Register file reads
    logic [`EX16_REG_W-1:0]  rf_a_idx;
    logic [`EX16_REG_W-1:0]  rf_b_idx;
    logic [`EX16_DATA_W-1:0] rf_a;
    logic [`EX16_DATA_W-1:0] rf_b;
    // Decode to execute
    logic                    dec_valid;
    logic                    dec_ready;
    ex16_opc_e               dec_op;
    logic [`EX16_REG_W-1:0]  dec_rd;
    logic [`EX16_DATA_W-1:0] dec_a;
    logic [`EX16_DATA_W-1:0] dec_b;
    logic [7:0]              dec_imm8;
    logic [3:0]              dec_shamt;
    logic                    dec_illegal;
    // Execute to result
    logic                    ex_valid;
    logic                    ex_ready;
    logic [`EX16_REG_W-1:0]  ex_rd;
    logic [`EX16_DATA_W-1:0] ex_data;
    logic [2:0]              ex_flags;
    logic [2:0]              ex_flag_mask;
    logic                    ex_wr;
    logic                    ex_illegal;

    ex16_decode decode0 (
        .clk, .rst, .in_valid, .in_ready, .in_instr,
        .rf_a_idx, .rf_b_idx, .rf_a, .rf_b,
        .ex_valid, .ex_rd,
        .dec_valid, .dec_ready, .dec_op, .dec_rd, .dec_a, .dec_b,
        .dec_imm8, .dec_shamt, .dec_illegal
    );

    ex16_execute execute0 (
        .clk, .rst,
        .dec_valid, .dec_ready, .dec_op, .dec_rd, .dec_a, .dec_b,
        .dec_imm8, .dec_shamt, .dec_illegal,
        .ex_valid, .ex_ready, .ex_rd, .ex_data, .ex_flags, .ex_flag_mask,
        .ex_wr, .ex_illegal
    );

    ex16_result result0 (
        .clk, .rst, .rf_a_idx, .rf_b_idx, .rf_a, .rf_b,
        .ex_valid, .ex_ready, .ex_rd, .ex_data, .ex_flags, .ex_flag_mask,
        .ex_wr, .ex_illegal,
        .res_valid, .res_ready, .res_data, .res_rd, .res_flags, .res_illegal
    );

endmodule

`default_nettype wire

/* dv/ex16_chk.sv */
// Bound to ex16_top; sees the result port and the execute handshake, counts no transactions
`default_nettype none

`include "ex16_macros.svh"

module ex16_chk (
    input logic                    clk,
    input logic                    rst,
    input logic                    res_valid,
    input logic                    res_ready,
    input logic [`EX16_DATA_W-1:0] res_data,
    input logic [`EX16_REG_W-1:0]  res_rd,
    input logic [2:0]              res_flags,
    input logic                    res_illegal,
    input logic                    ex_valid,
    input logic                    ex_ready,
    input logic                    ex_wr
);

    logic wr_q; // Write enable of the item now in the result register

    always_ff @(posedge clk) begin
        if (rst)
            wr_q <= 1'b0;
        else if (ex_valid && ex_ready)
            wr_q <= ex_wr; // Follows the output register load
    end

    ////////////////////////////////////////////////////////////
    // Result port protocol
    ////////////////////////////////////////////////////////////

    // Stalled item holds every field
    hold_stable: assert property (@(posedge clk) disable iff (rst)
        (res_valid && !res_ready) |=> (res_valid && $stable(res_data) && $stable(res_rd) &&
                                       $stable(res_flags) && $stable(res_illegal)))
        else $error("result fields changed while res_ready was low");

    reset_empty: assert property (@(posedge clk) rst |=> !res_valid)
        else $error("res_valid high in the cycle after reset");

    // Register 0 writes are dropped before the result stage
    no_r0_write: assert property (@(posedge clk) disable iff (rst)
        (res_valid && !res_illegal && wr_q) |-> (res_rd != '0))
        else $error("writing result retired with rd 0");

endmodule

bind ex16_top ex16_chk chk0 (
    .clk         (clk),
    .rst         (rst),
    .res_valid   (res_valid),
    .res_ready   (res_ready),
    .res_data    (res_data),
    .res_rd      (res_rd),
    .res_flags   (res_flags),
    .res_illegal (res_illegal),
    .ex_valid    (ex_valid),
    .ex_ready    (ex_ready),
    .ex_wr       (ex_wr)
);

`default_nettype wire

/* dv/ex16_tb.sv */
// Expected values come from an in-order model; data of illegal results is not checked
`default_nettype none

`include "ex16_macros.svh"

module ex16_tb import ex16_pkg::*; ();

    localparam int WAIT_LIMIT = 200; // Cycles per wait before giving up

    logic                    clk       = 1'b0;
    logic                    rst       = 1'b1;
    logic                    in_valid  = 1'b0;
    logic                    in_ready;
    logic [`EX16_DATA_W-1:0] in_instr  = '0;
    logic                    res_valid;
    logic                    res_ready = 1'b0;
    logic [`EX16_DATA_W-1:0] res_data;
    logic [`EX16_REG_W-1:0]  res_rd;
    logic [2:0]              res_flags;
    logic                    res_illegal;

    // Stimulus table
    string                   names    [$];
    logic [`EX16_DATA_W-1:0] words    [$];
    logic [`EX16_REG_W-1:0]  exp_rd   [$];
    logic [`EX16_DATA_W-1:0] exp_data [$];
    logic [2:0]              exp_flags[$];
    logic                    exp_ill  [$];

    logic [`EX16_DATA_W-1:0] model_regs [`EX16_NREGS]; // Reference register file
    logic [2:0]              model_flags;
    int                      pass_count = 0;
    int                      fail_count = 0;
    logic                    timed_out  = 1'b0;

    always #5 clk = ~clk;

    ex16_top dut0 (
        .clk, .rst, .in_valid, .in_ready, .in_instr,
        .res_valid, .res_ready, .res_data, .res_rd, .res_flags, .res_illegal
    );

    ////////////////////////////////////////////////////////////
    // Encoding and reference model
    ////////////////////////////////////////////////////////////

    function automatic logic [`EX16_DATA_W-1:0] encode_reg(input ex16_opc_e op,
            input logic [3:0] rd, input logic [3:0] rs, input logic [3:0] rt);
        return {op, rd, rs, rt}; // rt doubles as shift amount
    endfunction

    function automatic logic [`EX16_DATA_W-1:0] encode_imm(input ex16_opc_e op,
            input logic [3:0] rd, input logic [7:0] imm);
        return {op, rd, imm};
    endfunction

    task automatic push_test(input string name, input logic [`EX16_DATA_W-1:0] word);
        logic [`EX16_OPC_W-1:0]  op;
        logic [`EX16_REG_W-1:0]  rd;
        logic [`EX16_REG_W-1:0]  rs;
        logic [`EX16_REG_W-1:0]  rt;
        logic [7:0]              imm;
        logic [`EX16_DATA_W-1:0] a;
        logic [`EX16_DATA_W-1:0] b;
        logic [`EX16_DATA_W-1:0] data;
        logic [2:0]              fnew;
        logic [2:0]              fmask;
        logic                    ill;
        integer                  sa;
        integer                  sb;
        integer                  s;
        op    = word[15:12];
        rd    = word[11:8];
        rs    = word[7:4];
        rt    = word[3:0];
        imm   = word[7:0];
        a     = model_regs[rs];
        b     = model_regs[rt];
        sa    = {{16{a[15]}}, a}; // Signed view
        sb    = {{16{b[15]}}, b};
        s     = 0;
        data  = '0;
        fnew  = '0;
        fmask = '0;
        ill   = 1'b0;
        case (op)
            OPC_ADD, OPC_SUB: begin
                s = (op == OPC_ADD) ? sa + sb : sa - sb; // Exact value before the clamp
                if (s > 32767)
                    data = 16'h7fff;
                else if (s < -32768)
                    data = 16'h8000;
                else
                    data = s[15:0];
                fmask = 3'b111;
            end
            OPC_AND: data = a & b;
            OPC_NOR: data = ~(a | b);
            OPC_SLL: data = a << rt;
            OPC_SRL: data = a >> rt;
            OPC_SRA: data = (a >> rt) | (a[15] ? ~(16'hffff >> rt) : 16'h0000);
            OPC_LHB: data = {imm, model_regs[rd][7:0]};
            OPC_LLB: data = {model_regs[rd][15:8], imm};
            default: ill = 1'b1; // Nothing changes
        endcase
        if (op inside {OPC_AND, OPC_NOR, OPC_SLL, OPC_SRL, OPC_SRA})
            fmask[FLAG_Z] = 1'b1; // Z only for logic and shifts
        fnew[FLAG_Z] = (data == '0);
        fnew[FLAG_V] = (s > 32767) || (s < -32768);
        fnew[FLAG_N] = data[15];
        if (!ill && (rd != '0))
            model_regs[rd] = data;
        model_flags = (model_flags & ~fmask) | (fnew & fmask);
        names.push_back(name);
        words.push_back(word);
        exp_rd.push_back(rd);
        exp_data.push_back(data);
        exp_flags.push_back(model_flags);
        exp_ill.push_back(ill);
    endtask

    task automatic build_table();
        for (int r = 0; r < `EX16_NREGS; r++)
            model_regs[r] = '0;
        model_flags = '0;
        // Operand setup
        push_test("llb_r1", encode_imm(OPC_LLB, 4'd1, 8'h34));
        push_test("lhb_r1", encode_imm(OPC_LHB, 4'd1, 8'h12)); // Depends on r1
        push_test("llb_r2", encode_imm(OPC_LLB, 4'd2, 8'hff));
        push_test("llb_r3", encode_imm(OPC_LLB, 4'd3, 8'h00));
        push_test("lhb_r3", encode_imm(OPC_LHB, 4'd3, 8'h80));
        push_test("llb_r4", encode_imm(OPC_LLB, 4'd4, 8'hff));
        push_test("lhb_r4", encode_imm(OPC_LHB, 4'd4, 8'h7f));
        push_test("llb_r5", encode_imm(OPC_LLB, 4'd5, 8'h01));
        push_test("llb_r6", encode_imm(OPC_LLB, 4'd6, 8'hf0));
        push_test("lhb_r6", encode_imm(OPC_LHB, 4'd6, 8'hff));
        // Plain ALU ops
        push_test("add_basic", encode_reg(OPC_ADD, 4'd7, 4'd1, 4'd2));
        push_test("sub_neg", encode_reg(OPC_SUB, 4'd8, 4'd2, 4'd1));
        push_test("sub_zero", encode_reg(OPC_SUB, 4'd9, 4'd1, 4'd1));
        push_test("and_basic", encode_reg(OPC_AND, 4'd10, 4'd1, 4'd2));
        push_test("nor_basic", encode_reg(OPC_NOR, 4'd11, 4'd1, 4'd2));
        push_test("sll_basic", encode_reg(OPC_SLL, 4'd12, 4'd1, 4'd4));
        push_test("srl_basic", encode_reg(OPC_SRL, 4'd12, 4'd6, 4'd4));
        push_test("sra_neg", encode_reg(OPC_SRA, 4'd13, 4'd6, 4'd4));
        push_test("sra_pos", encode_reg(OPC_SRA, 4'd13, 4'd4, 4'd15));
        // Saturation, then logic ops leave V and N
        push_test("add_sat_pos", encode_reg(OPC_ADD, 4'd14, 4'd4, 4'd5));
        push_test("sub_sat_neg", encode_reg(OPC_SUB, 4'd14, 4'd3, 4'd5));
        push_test("and_keep_vn", encode_reg(OPC_AND, 4'd15, 4'd1, 4'd2));
        push_test("add_sat_neg", encode_reg(OPC_ADD, 4'd14, 4'd3, 4'd6));
        push_test("sub_sat_pos", encode_reg(OPC_SUB, 4'd14, 4'd4, 4'd6));
        push_test("nor_keep_vn", encode_reg(OPC_NOR, 4'd15, 4'd4, 4'd3));
        // Byte loads keep flags
        push_test("llb_keep_hi", encode_imm(OPC_LLB, 4'd1, 8'h99));
        push_test("lhb_keep_lo", encode_imm(OPC_LHB, 4'd1, 8'hab));
        // Dependent chain
        push_test("chain_add1", encode_reg(OPC_ADD, 4'd2, 4'd2, 4'd2));
        push_test("chain_add2", encode_reg(OPC_ADD, 4'd2, 4'd2, 4'd2));
        push_test("chain_sub", encode_reg(OPC_SUB, 4'd7, 4'd2, 4'd5));
        push_test("chain_and", encode_reg(OPC_AND, 4'd8, 4'd7, 4'd7));
        push_test("chain_sll", encode_reg(OPC_SLL, 4'd8, 4'd8, 4'd1));
        // Illegal codes and register 0
        push_test("illegal_f", 16'hf123);
        push_test("read_after_ill", encode_reg(OPC_ADD, 4'd9, 4'd1, 4'd0));
        push_test("illegal_7", 16'h7345);
        push_test("llb_r0", encode_imm(OPC_LLB, 4'd0, 8'h55));
        push_test("read_r0", encode_reg(OPC_ADD, 4'd9, 4'd0, 4'd5));
        push_test("lhb_r0", encode_imm(OPC_LHB, 4'd0, 8'h66));
    endtask

    ////////////////////////////////////////////////////////////
    // Driver, monitor and checks
    ////////////////////////////////////////////////////////////

    task automatic drive_all();
        int i;
        int gap;
        int guard;
        for (i = 0; i < words.size() && !timed_out; i++) begin
            gap = $urandom_range(2, 0);
            if (gap != 0) begin
                in_valid <= 1'b0; // Random bubble
                repeat (gap) @(posedge clk);
            end
            in_valid <= 1'b1;
            in_instr <= words[i];
            guard = 0;
            @(negedge clk);
            while (!in_ready && guard < WAIT_LIMIT) begin
                @(negedge clk);
                guard++;
            end
            if (!in_ready) begin
                $display("Timeout: instruction %0s was never accepted", names[i]);
                timed_out = 1'b1;
            end
            @(posedge clk); // Transfer edge
        end
        in_valid <= 1'b0;
    endtask

    task automatic check_result(input int j, input logic [`EX16_DATA_W-1:0] data,
            input logic [`EX16_REG_W-1:0] rd, input logic [2:0] flags, input logic ill);
        logic  ok;
        string exp_s;
        string got_s;
        ok = (rd == exp_rd[j]) && (flags == exp_flags[j]) && (ill == exp_ill[j]) &&
             (exp_ill[j] || (data == exp_data[j]));
        exp_s = $sformatf("rd %0d data %h flags %b illegal %b",
                          exp_rd[j], exp_data[j], exp_flags[j], exp_ill[j]);
        got_s = $sformatf("rd %0d data %h flags %b illegal %b", rd, data, flags, ill);
        assert (ok) else begin
            $display("FAILED %0s: expected %0s, got %0s", names[j], exp_s, got_s);
            fail_count++;
        end
        if (ok) begin
            $display("ok     %0s: rd %0d data %h flags %b illegal %b",
                     names[j], rd, data, flags, ill);
            pass_count++;
        end
    endtask

    task automatic consume_all();
        int   j;
        int   guard;
        logic took;
        for (j = 0; j < words.size() && !timed_out; j++) begin
            took  = 1'b0;
            guard = 0;
            while (!took && !timed_out) begin
                @(posedge clk);
                res_ready <= ($urandom_range(3, 0) != 0); // About one stall in four
                @(negedge clk);
                if (res_valid && res_ready) begin
                    took = 1'b1;
                end else begin
                    guard++;
                    if (guard >= WAIT_LIMIT) begin
                        $display("Timeout: result for %0s never arrived", names[j]);
                        timed_out = 1'b1;
                    end
                end
            end
            if (took)
                check_result(j, res_data, res_rd, res_flags, res_illegal);
        end
        @(posedge clk);
        res_ready <= 1'b0;
    endtask

    initial begin
        void'($urandom(32'hdeec5c86));
        build_table();
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        fork
            drive_all();
            consume_all();
        join
        $display("Summary: %0d tests, %0d passed, %0d failed",
                 words.size(), pass_count, fail_count);
        if ((fail_count == 0) && !timed_out && (pass_count == words.size())) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* ex16.f */
+incdir+include
design/ex16_pkg.sv
design/ex16_alu.sv
design/ex16_decode.sv
design/ex16_execute.sv
design/ex16_result.sv
design/ex16_top.sv
dv/ex16_chk.sv
dv/ex16_tb.sv

/* Makefile */
# Verilator simulation of the ex16 execute path

SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := ex16_tb
FILELIST := ex16.f
BUILD    := obj_dir
PASS_MSG := Test passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with $(SIM) and run $(TOP), pass only if the run passes"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD)
